/* rtl/larvaIoPkg.sv */
//////////////////////////////////////////////////
// Shared constants of the I/O subsystem
// Bus widths, unit numbers, UART divider, PWM period
// Referenced by scoped name from every RTL module
//////////////////////////////////////////////////
`default_nettype none

package larvaIoPkg;

	// CPU-side bus
	localparam int DATA_W = 32;                 // Data word
	localparam int STRB_W = DATA_W / 8;         // One strobe per byte lane
	localparam int ADDR_W = 6;                  // Word address, byte bits 7..2
	localparam int SUB_W  = 3;                  // Register select, byte bits 4..2
	localparam int UNIT_W = ADDR_W - SUB_W;     // Unit select, byte bits 7..5

	// Unit numbers in the upper address bits
	localparam logic [UNIT_W-1:0] UNIT_UART  = UNIT_W'(0);  // 0x00
	localparam logic [UNIT_W-1:0] UNIT_PWM   = UNIT_W'(1);  // 0x20, also gpin
	localparam logic [UNIT_W-1:0] UNIT_TIMER = UNIT_W'(3);  // 0x60
	localparam logic [UNIT_W-1:0] UNIT_IRQ   = UNIT_W'(7);  // 0xE0

	// UART bit timing
	localparam int UART_DIVIDER = 16;           // Clocks per serial bit
	localparam int DIV_W = $clog2(UART_DIVIDER);
	localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(UART_DIVIDER - 1);      // Divider wrap
	localparam logic [DIV_W-1:0] DIV_MID  = DIV_W'(UART_DIVIDER / 2 - 1);  // Mid-bit sample

	// PWM period is PWM_MAX + 1 clocks
	localparam int PWM_W = 8;
	localparam logic [PWM_W-1:0] PWM_MAX = PWM_W'(180);

	localparam int GPIN_W = 4;                  // General-purpose inputs

endpackage

`default_nettype wire

/* rtl/ioBus.sv */
//////////////////////////////////////////////////
// Decoded access strobes from the bridge to one unit
// Strobes are only high in the completing cycle
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

interface ioBus;

	logic write;                                // Completes with wstrb[0]
	logic read;                                 // Completes with no strobes
	logic fullWrite;                            // Completes with all four strobes
	logic [larvaIoPkg::SUB_W-1:0] subAddr;      // Register inside the unit
	logic [larvaIoPkg::DATA_W-1:0] wdata;

	// Bridge side drives everything
	modport bridge (
		output write,
		output read,
		output fullWrite,
		output subAddr,
		output wdata
	);

	// Peripheral side only listens
	modport unit (
		input write,
		input read,
		input fullWrite,
		input subAddr,
		input wdata
	);

endinterface

`default_nettype wire

/* rtl/ioBridge.sv */
//////////////////////////////////////////////////
// Bus bridge of the I/O block
// Unit decode, UART stall, gated strobes,
// free-running timer and the read-data mux
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ioBridge (
	input  wire clk,
	input  wire reset,
	input  wire sel,
	input  wire [larvaIoPkg::ADDR_W-1:0] addr,
	input  wire [larvaIoPkg::DATA_W-1:0] wdata,
	input  wire [larvaIoPkg::STRB_W-1:0] wstrb,
	ioBus.bridge uartBus,
	ioBus.bridge pwmBus,
	ioBus.bridge irqBus,
	input  wire txRdy,
	input  wire rxValid,
	input  wire rxOverrun,
	input  wire rxFrameErr,
	input  wire [7:0] rxData,
	input  wire pwmIrq,
	input  wire [2:0] irqEn,
	input  wire [larvaIoPkg::GPIN_W-1:0] gpin,
	output logic [larvaIoPkg::DATA_W-1:0] rdata,
	output logic stall
);

	logic [larvaIoPkg::UNIT_W-1:0] unit;
	logic [larvaIoPkg::SUB_W-1:0] subAddr;
	logic isWrite;                              // Any strobe set
	logic uartData;                             // Access to the UART data register
	logic done;                                 // Access completes this cycle
	logic uartHit, pwmHit, irqHit;
	logic [larvaIoPkg::DATA_W-1:0] timer;

	assign unit    = addr[larvaIoPkg::ADDR_W-1:larvaIoPkg::SUB_W];
	assign subAddr = addr[larvaIoPkg::SUB_W-1:0];
	assign isWrite = |wstrb;

	// Hold reads of an empty RX buffer and writes to a busy TX
	assign uartData = sel & (unit == larvaIoPkg::UNIT_UART) & (subAddr == '0);
	assign stall = uartData & ((~isWrite & ~rxValid) | (isWrite & ~txRdy));
	assign done  = sel & ~stall;

	assign uartHit = done & (unit == larvaIoPkg::UNIT_UART);
	assign pwmHit  = done & (unit == larvaIoPkg::UNIT_PWM);
	assign irqHit  = done & (unit == larvaIoPkg::UNIT_IRQ);

	////////////////////////////////////////////////////
	// Strobes, one set per unit
	assign uartBus.write     = uartHit & wstrb[0];
	assign uartBus.read      = uartHit & ~isWrite;
	assign uartBus.fullWrite = uartHit & (&wstrb);
	assign uartBus.subAddr   = subAddr;
	assign uartBus.wdata     = wdata;

	assign pwmBus.write      = pwmHit & wstrb[0];
	assign pwmBus.read       = pwmHit & ~isWrite;
	assign pwmBus.fullWrite  = pwmHit & (&wstrb);
	assign pwmBus.subAddr    = subAddr;
	assign pwmBus.wdata      = wdata;

	assign irqBus.write      = irqHit & wstrb[0];
	assign irqBus.read       = irqHit & ~isWrite;
	assign irqBus.fullWrite  = irqHit & (&wstrb);
	assign irqBus.subAddr    = subAddr;
	assign irqBus.wdata      = wdata;

	// Timer just counts clocks
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			timer <= '0;
		end else begin
			timer <= timer + 1'b1;
		end
	end

	////////////////////////////////////////////////////
	// Read mux, combinational from the address
	always_comb begin
		rdata = '0;
		case (unit)
			larvaIoPkg::UNIT_UART: begin
				if (subAddr == '0) begin
					rdata[7:0] = rxData;                // RX buffer
				end else begin
					rdata[4:0] = {pwmIrq, rxOverrun, rxFrameErr, txRdy, rxValid};
				end
			end
			larvaIoPkg::UNIT_PWM:   rdata[larvaIoPkg::GPIN_W-1:0] = gpin;  // PWM unit is write only
			larvaIoPkg::UNIT_TIMER: rdata = timer;
			larvaIoPkg::UNIT_IRQ:   rdata[2:0] = irqEn;
			default:                rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

/* rtl/uartTx.sv */
//////////////////////////////////////////////////
// UART transmitter, 8N1 at a fixed divider
// Write to sub-address 0 starts a frame
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module uartTx (
	input  wire clk,
	input  wire reset,
	ioBus.unit bus,
	output logic txd,
	output logic txRdy
);

	logic load;                                 // New byte accepted
	logic [larvaIoPkg::DIV_W-1:0] txDiv;
	logic divWrap;                              // End of one bit time
	logic [8:0] txSh;                           // Data plus start bit
	logic [3:0] bitCnt;                         // Bits left, zero when idle

	assign load    = bus.write & (bus.subAddr == '0);
	assign divWrap = (txDiv == larvaIoPkg::DIV_LAST);

	// Baud divider, restarted on a load so the start bit is full length
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txDiv <= '0;
		end else if (load | divWrap) begin
			txDiv <= '0;
		end else begin
			txDiv <= txDiv + 1'b1;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			txSh   <= '1;                           // Line idles high
			bitCnt <= '0;
		end else if (load) begin
			txSh   <= {bus.wdata[7:0], 1'b0};
			bitCnt <= 4'd10;                        // Start, 8 data, stop
		end else if (divWrap) begin
			txSh <= {1'b1, txSh[8:1]};              // Ones fill in as stop bit
			if (bitCnt != '0) begin
				bitCnt <= bitCnt - 1'b1;
			end
		end
	end

	assign txd   = txSh[0];
	assign txRdy = (bitCnt == '0);

endmodule

`default_nettype wire

/* rtl/uartRx.sv */
//////////////////////////////////////////////////
// UART receiver, 8N1 at a fixed divider
// Read of sub-address 0 returns the byte and
// clears the valid and overrun flags
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module uartRx (
	input  wire clk,
	input  wire reset,
	ioBus.unit bus,
	input  wire rxd,
	output logic [7:0] rxData,
	output logic rxValid,
	output logic rxOverrun,
	output logic rxFrameErr
);

	logic [1:0] rxSync;                         // [0] newest sample
	logic rxEdge;
	logic [larvaIoPkg::DIV_W-1:0] rxDiv;
	logic rxSample;                             // Middle of a bit
	logic [9:0] rxSh;
	logic rxDone;                               // Start bit reached bit 0
	logic rxStop;                               // Stop bit of the buffered byte
	logic [1:0] rxFlags;                        // 01 valid, 11 overrun

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxSync <= 2'b11;
		end else begin
			rxSync <= {rxSync[0], rxd};
		end
	end

	assign rxEdge   = rxSync[1] ^ rxSync[0];
	assign rxSample = (rxDiv == larvaIoPkg::DIV_MID);
	assign rxDone   = ~rxSh[0];

	// Divider realigns on every line edge
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxDiv <= '0;
		end else if (rxEdge | (rxDiv == larvaIoPkg::DIV_LAST)) begin
			rxDiv <= '0;
		end else begin
			rxDiv <= rxDiv + 1'b1;
		end
	end

	////////////////////////////////////////////////////
	// Shifter, buffer and flags
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxSh <= '1;
		end else if (rxDone) begin
			rxSh <= '1;                             // Frame captured, rearm
		end else if (rxSample) begin
			rxSh <= {rxSync[1], rxSh[9:1]};
		end
	end

	always_ff @(posedge clk) begin
		if (rxDone) begin
			rxData <= rxSh[8:1];
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rxStop  <= 1'b1;
			rxFlags <= '0;
		end else if (rxDone) begin
			rxStop  <= rxSh[9];
			rxFlags <= {rxFlags[0], 1'b1};          // Overrun if still unread
		end else if (bus.read & (bus.subAddr == '0)) begin
			rxFlags <= '0;
		end
	end

	assign rxValid    = rxFlags[0];
	assign rxOverrun  = rxFlags[1];
	assign rxFrameErr = ~rxStop;

endmodule

`default_nettype wire

/* rtl/pwmGen.sv */
//////////////////////////////////////////////////
// PWM generator with a period of PWM_MAX + 1 clocks
// Duty is written any time, used from the next period
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module pwmGen (
	input  wire clk,
	input  wire reset,
	ioBus.unit bus,
	output logic pwmOut,
	output logic pwmIrq
);

	logic [larvaIoPkg::PWM_W-1:0] pwmCnt;
	logic [larvaIoPkg::PWM_W-1:0] pwmDuty;      // As written
	logic [larvaIoPkg::PWM_W-1:0] pwmBuf;       // Duty of the running period
	logic lastCnt, zeroCnt;

	assign lastCnt = (pwmCnt == larvaIoPkg::PWM_MAX);
	assign zeroCnt = (pwmCnt == '0);

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pwmCnt  <= '0;
			pwmDuty <= '0;
			pwmBuf  <= '0;
			pwmOut  <= 1'b0;
			pwmIrq  <= 1'b0;
		end else begin
			pwmCnt <= lastCnt ? '0 : pwmCnt + 1'b1;
			if (bus.write) begin
				pwmDuty <= bus.wdata[larvaIoPkg::PWM_W-1:0];
			end
			if (lastCnt) begin
				pwmBuf <= pwmDuty;                  // Glitch-free duty change
			end
			// Match wins over zero, so duty 0 stays low
			if (pwmCnt == pwmBuf) begin
				pwmOut <= 1'b0;
			end else if (zeroCnt) begin
				pwmOut <= 1'b1;
			end
			// Period start flag, any PWM write acknowledges
			if (zeroCnt) begin
				pwmIrq <= 1'b1;
			end else if (bus.write) begin
				pwmIrq <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

/* rtl/irqCtrl.sv */
//////////////////////////////////////////////////
// Interrupt controller
// Enables at subAddr 0..3, vectors at 4..7 (full words)
// Fixed priority: trap, RX, TX, PWM
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module irqCtrl (
	input  wire clk,
	input  wire reset,
	ioBus.unit bus,
	input  wire rxValid,
	input  wire txRdy,
	input  wire pwmIrq,
	input  wire trap,
	output logic [2:0] irqEn,
	output logic irq,
	output logic [larvaIoPkg::DATA_W-1:2] ivector
);

	logic [larvaIoPkg::DATA_W-1:2] vecTab [4];  // Word-aligned handler addresses
	logic [2:0] irqPen;                         // Enabled and pending
	logic [1:0] vecSel;

	// Enable bits: 0 RX, 1 TX, 2 PWM
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			irqEn <= '0;
		end else if (bus.write & ~bus.subAddr[2]) begin
			irqEn <= bus.wdata[2:0];
		end
	end

	always_ff @(posedge clk) begin
		if (bus.fullWrite & bus.subAddr[2]) begin
			vecTab[bus.subAddr[1:0]] <= bus.wdata[larvaIoPkg::DATA_W-1:2];
		end
	end

	////////////////////////////////////////////////////
	// Priority encoder
	assign irqPen = irqEn & {pwmIrq, txRdy, rxValid};

	always_comb begin
		if (trap) begin
			vecSel = 2'd0;                          // ECALL, EBREAK
		end else if (irqPen[0]) begin
			vecSel = 2'd1;                          // UART RX
		end else if (irqPen[1]) begin
			vecSel = 2'd2;                          // UART TX
		end else begin
			vecSel = 2'd3;                          // PWM, or nothing pending
		end
	end

	assign ivector = vecTab[vecSel];
	assign irq     = (|irqPen) | trap;

endmodule

`default_nettype wire

/* rtl/larvaIo.sv */
//////////////////////////////////////////////////
// Top of the memory-mapped I/O block
// Word bus in, serial lines, PWM and interrupt out
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module larvaIo (
	input  wire clk,
	input  wire reset,
	input  wire sel,
	input  wire [larvaIoPkg::ADDR_W-1:0] addr,
	input  wire [larvaIoPkg::DATA_W-1:0] wdata,
	input  wire [larvaIoPkg::STRB_W-1:0] wstrb,
	input  wire [larvaIoPkg::GPIN_W-1:0] gpin,
	input  wire rxd,
	input  wire trap,
	output logic [larvaIoPkg::DATA_W-1:0] rdata,
	output logic stall,
	output logic txd,
	output logic pwmOut,
	output logic irq,
	output logic [larvaIoPkg::DATA_W-1:2] ivector
);

	// Status flags back to the bridge and the interrupt controller
	logic txRdy, rxValid, rxOverrun, rxFrameErr;
	logic [7:0] rxData;
	logic pwmIrq;
	logic [2:0] irqEn;

	ioBus uartBus ();
	ioBus pwmBus ();
	ioBus irqBus ();

	ioBridge i_ioBridge (
		.clk, .reset, .sel, .addr, .wdata, .wstrb,
		.uartBus, .pwmBus, .irqBus,
		.txRdy, .rxValid, .rxOverrun, .rxFrameErr, .rxData,
		.pwmIrq, .irqEn, .gpin,
		.rdata, .stall
	);

	// TX and RX share one strobe set
	uartTx i_uartTx (
		.clk, .reset, .bus(uartBus),
		.txd, .txRdy
	);

	uartRx i_uartRx (
		.clk, .reset, .bus(uartBus), .rxd,
		.rxData, .rxValid, .rxOverrun, .rxFrameErr
	);

	pwmGen i_pwmGen (
		.clk, .reset, .bus(pwmBus),
		.pwmOut, .pwmIrq
	);

	irqCtrl i_irqCtrl (
		.clk, .reset, .bus(irqBus),
		.rxValid, .txRdy, .pwmIrq, .trap,
		.irqEn, .irq, .ivector
	);

endmodule

`default_nettype wire

/* testbench/larvaIoTb.sv */
//////////////////////////////////////////////////
// Testbench of the I/O block
// Random bus traffic, serial line models and a
// reference model for UART, PWM, timer and IRQs
//////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module larvaIoTb;

	localparam int CLK_PERIOD = 100;
	localparam int FRAME      = 10 * larvaIoPkg::UART_DIVIDER;   // Clocks per 8N1 frame
	localparam int PERIOD     = int'(larvaIoPkg::PWM_MAX) + 1;   // Clocks per PWM period
	localparam int IRQ_LOOPS  = 12;
	localparam int POLL_MAX   = 256;
	// Each test worst case in frames and periods, plus slack
	localparam int WATCHDOG_CYCLES = (8 + 2 * IRQ_LOOPS) * (FRAME + PERIOD) + 2000;

	// Register addresses, word granular
	localparam logic [5:0] ADDR_DATA   = {larvaIoPkg::UNIT_UART, 3'd0};
	localparam logic [5:0] ADDR_STATUS = {larvaIoPkg::UNIT_UART, 3'd1};
	localparam logic [5:0] ADDR_PWM    = {larvaIoPkg::UNIT_PWM, 3'd0};    // Read gives gpin
	localparam logic [5:0] ADDR_TIMER  = {larvaIoPkg::UNIT_TIMER, 3'd0};
	localparam logic [5:0] ADDR_IRQEN  = {larvaIoPkg::UNIT_IRQ, 3'd0};
	localparam logic [5:0] ADDR_VEC    = {larvaIoPkg::UNIT_IRQ, 3'd4};

	logic clk;
	logic reset;
	logic sel;
	logic [larvaIoPkg::ADDR_W-1:0] addr;
	logic [larvaIoPkg::DATA_W-1:0] wdata;
	logic [larvaIoPkg::STRB_W-1:0] wstrb;
	logic [larvaIoPkg::GPIN_W-1:0] gpin;
	logic rxd;
	logic trap;
	logic [larvaIoPkg::DATA_W-1:0] rdata;
	logic stall;
	logic txd;
	logic pwmOut;
	logic irq;
	logic [larvaIoPkg::DATA_W-1:2] ivector;

	larvaIo i_larvaIo (
		.clk, .reset, .sel, .addr, .wdata, .wstrb, .gpin, .rxd, .trap,
		.rdata, .stall, .txd, .pwmOut, .irq, .ivector
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////
	// Helpers
	task automatic checkValue(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
			$display("TESTS FAILED");
			$fatal(1);
		end
	endtask

	// One access, held while stall is high, rdata taken in the completing cycle
	task automatic busAccess(input logic [5:0] a, input logic [31:0] d, input logic [3:0] s,
			output logic [31:0] r, output int waits);
		waits = 0;
		@(posedge clk);
		sel   <= 1'b1;
		addr  <= a;
		wdata <= d;
		wstrb <= s;
		@(negedge clk);
		while (stall) begin
			waits++;
			@(negedge clk);
		end
		r = rdata;
		@(posedge clk);                             // Completes here
		sel   <= 1'b0;
		wstrb <= '0;
	endtask

	task automatic readReg(input logic [5:0] a, output logic [31:0] r);
		int waits;
		busAccess(a, '0, 4'h0, r, waits);
	endtask

	task automatic writeReg(input logic [5:0] a, input logic [31:0] d, input logic [3:0] s);
		logic [31:0] r;
		int waits;
		busAccess(a, d, s, r, waits);
	endtask

	// Bounded poll of UART status until all mask bits are set
	task automatic pollStatus(input logic [4:0] mask, output logic [31:0] status);
		int n;
		n = 0;
		readReg(ADDR_STATUS, status);
		while (((status[4:0] & mask) != mask) && (n < POLL_MAX)) begin
			readReg(ADDR_STATUS, status);
			n++;
		end
	endtask

	// Serial source on rxd, LSB first
	task automatic sendSerial(input logic [7:0] b, input logic stopBit);
		logic [9:0] frame;
		int i;
		frame = {stopBit, b, 1'b0};
		for (i = 0; i < 10; i++) begin
			@(posedge clk);
			rxd <= frame[i];
			repeat (larvaIoPkg::UART_DIVIDER - 1) @(posedge clk);
		end
		@(posedge clk);
		rxd <= 1'b1;                                // Back to idle
	endtask

	// Serial sink on txd, samples near mid-bit after the start edge
	task automatic receiveTx(output logic [9:0] frame);
		int i;
		@(negedge clk);
		while (txd) @(negedge clk);
		repeat (larvaIoPkg::UART_DIVIDER / 2 - 1) @(negedge clk);
		for (i = 0; i < 10; i++) begin
			if (i != 0) begin
				repeat (larvaIoPkg::UART_DIVIDER) @(negedge clk);
			end
			frame[i] = txd;
		end
	endtask

	task automatic countHigh(output int n);
		int i;
		n = 0;
		for (i = 0; i < PERIOD; i++) begin
			@(negedge clk);
			if (pwmOut) n++;
		end
	endtask

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
		$display("TESTS FAILED");
		$fatal(1);
	end

	////////////////////////////////////////////////////
	// Test sequence
	initial begin
		int unsigned seed;
		logic [31:0] rnd, r, st, t1, t2;
		logic [7:0] b1, b2;
		logic [9:0] frameA, frameB;
		logic [29:0] vec [4];
		logic [2:0] en, pend;
		logic trapV, rxPend, txBusy, pwmPend, rxPending, expIrq;
		logic [29:0] expVec;
		int waits, idle, highs, duty, i, k;

		seed  = $urandom(68);
		clk   = 1'b0;
		reset = 1'b1;
		sel   = 1'b0;
		addr  = '0;
		wdata = '0;
		wstrb = '0;
		gpin  = '0;
		rxd   = 1'b1;
		trap  = 1'b0;
		repeat (2) @(posedge clk);
		reset <= 1'b0;

		// UART transmit, second write lands while busy
		rnd = $urandom;
		b1  = rnd[7:0];
		b2  = rnd[15:8];
		fork
			receiveTx(frameA);
			begin
				writeReg(ADDR_DATA, {rnd[31:8], b1}, 4'hF);
				busAccess(ADDR_DATA, {24'h0, b2}, 4'hF, r, waits);
			end
		join
		receiveTx(frameB);
		checkValue("tx frame 1", {22'h0, 1'b1, b1, 1'b0}, frameA);
		checkValue("tx busy stall", 1, waits > 0);
		checkValue("tx frame 2", {22'h0, 1'b1, b2, 1'b0}, frameB);

		// UART receive
		rnd = $urandom;
		sendSerial(rnd[7:0], 1'b1);
		pollStatus(5'b00001, st);
		checkValue("rx valid", 1, st[0]);
		readReg(ADDR_DATA, r);
		checkValue("rx data", rnd[7:0], r);
		readReg(ADDR_STATUS, st);
		checkValue("rx status after read", 4'b0010, st[3:0]);   // Only txRdy

		// Overrun, then frame error
		rnd = $urandom;
		sendSerial(rnd[7:0], 1'b1);
		sendSerial(rnd[15:8], 1'b1);
		pollStatus(5'b01001, st);
		checkValue("rx overrun", 1, st[3]);
		readReg(ADDR_DATA, r);
		checkValue("rx overrun data", rnd[15:8], r);
		readReg(ADDR_STATUS, st);
		checkValue("rx overrun cleared", 4'b0010, st[3:0]);
		sendSerial(rnd[23:16], 1'b0);
		pollStatus(5'b00001, st);
		checkValue("rx frame error", 1, st[2]);
		readReg(ADDR_DATA, r);
		checkValue("rx frame error data", rnd[23:16], r);
		// Read of the empty buffer is held until the byte lands
		fork
			sendSerial(rnd[31:24], 1'b1);
			busAccess(ADDR_DATA, '0, 4'h0, r, waits);
		join
		checkValue("rx empty stall", 1, waits > 0);
		checkValue("rx data after stall", rnd[31:24], r);
		readReg(ADDR_STATUS, st);
		checkValue("rx frame error gone", 0, st[2]);

		// PWM duty and period flag
		duty = 1 + ($urandom % int'(larvaIoPkg::PWM_MAX));
		writeReg(ADDR_PWM, duty, 4'h1);
		repeat (2 * PERIOD) @(posedge clk);         // Buffer reload plus one clean period
		for (k = 0; k < 2; k++) begin
			countHigh(highs);
			checkValue("pwm high cycles", duty, highs);
		end
		writeReg(ADDR_PWM, duty, 4'h1);             // Clear, next set is a fresh period start
		pollStatus(5'b10000, st);
		checkValue("pwm irq set", 1, st[4]);
		writeReg(ADDR_PWM, duty, 4'h1);
		readReg(ADDR_STATUS, st);
		checkValue("pwm irq cleared", 0, st[4]);

		// Timer and inputs
		idle = $urandom % 64;
		readReg(ADDR_TIMER, t1);
		repeat (idle) @(posedge clk);
		readReg(ADDR_TIMER, t2);
		checkValue("timer delta", idle + 2, t2 - t1);     // Idle plus two access cycles
		rnd = $urandom;
		@(posedge clk);
		gpin <= rnd[3:0];
		readReg(ADDR_PWM, r);
		checkValue("gpin read", {28'h0, rnd[3:0]}, r);

		////////////////////////////////////////////////////
		// Interrupt controller
		for (i = 0; i < 4; i++) begin
			rnd    = $urandom;
			vec[i] = rnd[31:2];
			writeReg(6'(ADDR_VEC + i), rnd, 4'hF);
		end
		rxPending = 1'b0;
		for (k = 0; k < IRQ_LOOPS; k++) begin
			rnd     = $urandom;
			en      = rnd[2:0];
			trapV   = rnd[3];
			rxPend  = rnd[4];
			txBusy  = rnd[5];
			pwmPend = rnd[6];
			writeReg(ADDR_IRQEN, {29'h0, en}, 4'hF);
			readReg(ADDR_IRQEN, r);
			checkValue("irq enable readback", {29'h0, en}, r);
			if (rxPend && !rxPending) begin
				sendSerial(rnd[15:8], 1'b1);
				pollStatus(5'b00001, st);
			end else if (!rxPend && rxPending) begin
				readReg(ADDR_DATA, r);
			end
			rxPending = rxPend;
			pollStatus(5'b00010, st);               // TX idle, no stall later
			writeReg(ADDR_PWM, duty, 4'h1);
			pollStatus(5'b10000, st);               // Just past period start
			if (!pwmPend) begin
				writeReg(ADDR_PWM, duty, 4'h1);
			end
			if (txBusy) begin
				writeReg(ADDR_DATA, rnd[23:16], 4'hF);
			end
			@(posedge clk);
			trap <= trapV;
			@(negedge clk);
			// Model of the fixed priority
			pend   = en & {pwmPend, ~txBusy, rxPend};
			expIrq = trapV | (|pend);
			if (trapV) expVec = vec[0];
			else if (pend[0]) expVec = vec[1];
			else if (pend[1]) expVec = vec[2];
			else expVec = vec[3];
			checkValue("irq line", expIrq, irq);
			if (expIrq) begin
				checkValue("irq vector", {2'b00, expVec}, {2'b00, ivector});
			end
			@(posedge clk);
			trap <= 1'b0;
		end

		$display("TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
rtl/larvaIoPkg.sv
rtl/ioBus.sv
rtl/ioBridge.sv
rtl/uartTx.sv
rtl/uartRx.sv
rtl/pwmGen.sv
rtl/irqCtrl.sv
rtl/larvaIo.sv
testbench/larvaIoTb.sv
